/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int DATA_BITS       = 32;
    localparam int COPY_WORDS      = 27;                // Words in the copy image.
    localparam int COPY_INDEX_BITS = $clog2(COPY_WORDS);

    // ----------------------------------------
    // Opcodes and payload structs
    // ----------------------------------------
    typedef enum logic [1:0] {
        MEM_NOP    = 2'd0,
        MEM_LOAD   = 2'd1,
        MEM_STORE  = 2'd2,
        MEM_BRANCH = 2'd3
    } mem_opcode_t;

    // Operation handed over by the execute stage, 99 bits.
    typedef struct packed {
        mem_opcode_t          opcode;
        logic                 zero;    // ALU zero flag.
        logic [DATA_BITS-1:0] addr;    // Byte address.
        logic [DATA_BITS-1:0] wdata;
        logic [DATA_BITS-1:0] pc;
    } mem_op_t;

    // Result passed on to writeback, 65 bits.
    typedef struct packed {
        logic [DATA_BITS-1:0] pc;
        logic [DATA_BITS-1:0] rdata;   // Zero unless a load.
        logic                 branch_taken;
    } mem_result_t;

    typedef logic [COPY_WORDS-1:0][DATA_BITS-1:0] copy_image_t;

endpackage

`default_nettype wire

/* mem_request_queue.sv */
`default_nettype none

module mem_request_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk_50,
    input  logic              reset,
    input  logic              op_valid,
    input  mem_pkg::mem_op_t  op,
    input  logic              pop,
    output logic              head_valid,
    output mem_pkg::mem_op_t  head,
    output logic              credit_return
);
    import mem_pkg::*;

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    mem_op_t             buffer [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Upstream credits guarantee a free slot.
    always_ff @(posedge clk_50) begin
        if (op_valid) begin
            buffer[wr_ptr] <= op;
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (op_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count         <= count + CNT_BITS'(op_valid) - CNT_BITS'(pop);
            credit_return <= pop;                           // One credit per pop.
        end
    end

    assign head_valid = (count != '0);
    assign head       = buffer[rd_ptr];

endmodule

`default_nettype wire

/* copy_sequencer.sv */
`default_nettype none

module copy_sequencer (
    input  logic clk_50,
    input  logic reset,
    input  logic copy_start,
    input  logic access_idle,
    input  logic last_word,
    output logic count_clear,
    output logic count_step,
    output logic copy_we,
    output logic copy_busy
);

    typedef enum logic [1:0] {
        CP_IDLE,
        CP_DRAIN,
        CP_WRITE
    } cp_state_t;

    cp_state_t state;
    cp_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            CP_IDLE: begin
                if (copy_start) begin
                    state_next = CP_DRAIN;
                end
            end
            CP_DRAIN: begin
                if (access_idle) begin
                    state_next = CP_WRITE;                  // In-flight op retired.
                end
            end
            CP_WRITE: begin
                if (last_word) begin
                    state_next = CP_IDLE;
                end
            end
            default: state_next = CP_IDLE;
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            state <= CP_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign count_clear = (state == CP_IDLE) && copy_start;  // Index 0 on entry to drain.
    assign count_step  = (state == CP_WRITE);
    assign copy_we     = (state == CP_WRITE);
    assign copy_busy   = (state != CP_IDLE);                // Also blocks pops.

endmodule

`default_nettype wire

/* word_counter.sv */
`default_nettype none

module word_counter (
    input  logic                                clk_50,
    input  logic                                reset,
    input  logic                                clear,
    input  logic                                step,
    output logic [mem_pkg::COPY_INDEX_BITS-1:0] index,
    output logic                                last_word
);
    import mem_pkg::*;

    always_ff @(posedge clk_50) begin
        if (reset) begin
            index <= '0;
        end else if (clear) begin
            index <= '0;
        end else if (step) begin
            index <= last_word ? '0 : index + 1'b1;         // Wraps after the last word.
        end
    end

    assign last_word = (index == COPY_INDEX_BITS'(COPY_WORDS - 1));

endmodule

`default_nettype wire

/* data_mem.sv */
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS = 64
) (
    input  logic                                clk_50,
    input  logic                                mem_en,
    input  logic                                mem_we,
    input  logic [$clog2(MEM_WORDS)-1:0]        mem_addr,
    input  logic [mem_pkg::DATA_BITS-1:0]       mem_wdata,
    input  logic                                copy_we,
    input  logic [mem_pkg::COPY_INDEX_BITS-1:0] copy_index,
    input  mem_pkg::copy_image_t                copy_image,
    output logic [mem_pkg::DATA_BITS-1:0]       mem_rdata
);
    import mem_pkg::*;

    logic [DATA_BITS-1:0] mem [MEM_WORDS];

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    always_ff @(posedge clk_50) begin
        if (copy_we) begin
            mem[copy_index] <= copy_image[copy_index];      // Copy image word.
        end else if (mem_en && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // ----------------------------------------
    // Read side
    // ----------------------------------------
    // Output holds its value between reads.
    always_ff @(posedge clk_50) begin
        if (mem_en && !mem_we) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

`default_nettype wire

/* mem_access.sv */
`default_nettype none

module mem_access #(
    parameter int MEM_WORDS = 64
) (
    input  logic                          clk_50,
    input  logic                          reset,
    input  logic                          head_valid,
    input  mem_pkg::mem_op_t              head,
    input  logic                          copy_busy,
    input  logic [mem_pkg::DATA_BITS-1:0] mem_rdata,
    output logic                          pop,
    output logic                          mem_en,
    output logic                          mem_we,
    output logic [$clog2(MEM_WORDS)-1:0]  mem_addr,
    output logic [mem_pkg::DATA_BITS-1:0] mem_wdata,
    output logic                          access_idle,
    output logic                          result_valid,
    output mem_pkg::mem_result_t          result
);
    import mem_pkg::*;

    localparam int ADDR_BITS = $clog2(MEM_WORDS);

    logic                 flight_valid;
    mem_opcode_t          flight_opcode;
    logic [DATA_BITS-1:0] flight_pc;
    logic                 flight_branch;

    // ----------------------------------------
    // Issue to memory
    // ----------------------------------------
    assign pop       = head_valid && !copy_busy;
    assign mem_en    = pop && ((head.opcode == MEM_LOAD) || (head.opcode == MEM_STORE));
    assign mem_we    = pop && (head.opcode == MEM_STORE);
    assign mem_addr  = ADDR_BITS'((head.addr >> 2) % MEM_WORDS);  // Word address.
    assign mem_wdata = head.wdata;

    // ----------------------------------------
    // In-flight and result registers
    // ----------------------------------------
    always_ff @(posedge clk_50) begin
        if (reset) begin
            flight_valid <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            flight_valid <= pop;
            result_valid <= flight_valid;
        end
    end

    always_ff @(posedge clk_50) begin
        if (pop) begin
            flight_opcode <= head.opcode;
            flight_pc     <= head.pc;
            flight_branch <= (head.opcode == MEM_BRANCH) && head.zero;
        end
        if (flight_valid) begin
            result.pc           <= flight_pc;
            result.rdata        <= (flight_opcode == MEM_LOAD) ? mem_rdata : '0;
            result.branch_taken <= flight_branch;
        end
    end

    assign access_idle = !flight_valid;                     // Nothing waiting on memory.

endmodule

`default_nettype wire

/* mem_stage.sv */
`default_nettype none

module mem_stage #(
    parameter int MEM_WORDS   = 64,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk_50,
    input  logic                  reset,
    input  logic                  op_valid,
    input  mem_pkg::mem_op_t      op,
    input  logic                  copy_start,
    input  mem_pkg::copy_image_t  copy_image,
    output logic                  credit_return,
    output logic                  result_valid,
    output mem_pkg::mem_result_t  result,
    output logic                  copy_busy
);
    import mem_pkg::*;

    // Queue to access path.
    logic    head_valid;
    mem_op_t head;
    logic    pop;

    // Access path to memory.
    logic                         mem_en;
    logic                         mem_we;
    logic [$clog2(MEM_WORDS)-1:0] mem_addr;
    logic [DATA_BITS-1:0]         mem_wdata;
    logic [DATA_BITS-1:0]         mem_rdata;
    logic                         access_idle;

    // Copy engine.
    logic                       count_clear;
    logic                       count_step;
    logic                       copy_we;
    logic                       last_word;
    logic [COPY_INDEX_BITS-1:0] copy_index;

    mem_request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_50        (clk_50),
        .reset         (reset),
        .op_valid      (op_valid),
        .op            (op),
        .pop           (pop),
        .head_valid    (head_valid),
        .head          (head),
        .credit_return (credit_return)
    );

    mem_access #(
        .MEM_WORDS (MEM_WORDS)
    ) u_access (
        .clk_50       (clk_50),
        .reset        (reset),
        .head_valid   (head_valid),
        .head         (head),
        .copy_busy    (copy_busy),
        .mem_rdata    (mem_rdata),
        .pop          (pop),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .access_idle  (access_idle),
        .result_valid (result_valid),
        .result       (result)
    );

    copy_sequencer u_copy_seq (
        .clk_50      (clk_50),
        .reset       (reset),
        .copy_start  (copy_start),
        .access_idle (access_idle),
        .last_word   (last_word),
        .count_clear (count_clear),
        .count_step  (count_step),
        .copy_we     (copy_we),
        .copy_busy   (copy_busy)
    );

    word_counter u_word_counter (
        .clk_50    (clk_50),
        .reset     (reset),
        .clear     (count_clear),
        .step      (count_step),
        .index     (copy_index),
        .last_word (last_word)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_mem (
        .clk_50     (clk_50),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .copy_we    (copy_we),
        .copy_index (copy_index),
        .copy_image (copy_image),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

/* tb_mem_stage.sv */
`default_nettype none

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int MEM_WORDS   = 64;
    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_OPS     = 600;
    localparam int SEED        = 32'h9c8f_4b15;

    logic        clk_50;
    logic        reset;
    logic        op_valid;
    mem_op_t     op;
    logic        copy_start;
    copy_image_t copy_image;
    logic        credit_return;
    logic        result_valid;
    mem_result_t result;
    logic        copy_busy;

    // Reference model state.
    logic [DATA_BITS-1:0] shadow [MEM_WORDS];
    bit                   written [MEM_WORDS];
    mem_result_t          expected [$];
    int                   credits = QUEUE_DEPTH;
    int                   issued = 0;
    int                   returned = 0;
    int                   copies = 0;
    int                   cycle_count = 0;
    logic [DATA_BITS-1:0] next_pc = 32'h0000_1000;
    bit                   copy_wanted = 1'b0;

    mem_stage #(
        .MEM_WORDS   (MEM_WORDS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) UUT (
        .clk_50        (clk_50),
        .reset         (reset),
        .op_valid      (op_valid),
        .op            (op),
        .copy_start    (copy_start),
        .copy_image    (copy_image),
        .credit_return (credit_return),
        .result_valid  (result_valid),
        .result        (result),
        .copy_busy     (copy_busy)
    );

    initial begin
        clk_50 = 1'b0;
        forever #2 clk_50 = ~clk_50;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected_val);
        if (actual !== expected_val) begin
            abort_run($sformatf("FAIL at %0t ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, actual, expected_val));
        end
    endtask

    // Outputs are read before the edge updates them.
    task automatic sample_outputs();
        mem_result_t exp_res;
        if (credit_return === 1'b1) begin
            credits++;
            returned++;
            if (credits > QUEUE_DEPTH) begin
                abort_run("ERROR: more credits were returned than were spent");
            end
        end
        if (result_valid === 1'b1) begin
            if (expected.size() == 0) begin
                abort_run("ERROR: a result arrived with no operation outstanding");
            end
            exp_res = expected.pop_front();
            check("result.pc", result.pc, exp_res.pc);
            check("result.rdata", result.rdata, exp_res.rdata);
            check("result.branch_taken", 32'(result.branch_taken),
                  32'(exp_res.branch_taken));
        end
    endtask

    task automatic tick();
        @(posedge clk_50);
        op_valid   <= 1'b0;
        copy_start <= 1'b0;
        sample_outputs();
    endtask

    task automatic issue_op();
        mem_op_t     o;
        mem_result_t exp_res;
        int unsigned w;
        w        = $urandom_range(MEM_WORDS - 1);
        o.opcode = mem_opcode_t'($urandom_range(3));
        if (o.opcode == MEM_LOAD && !written[w]) begin
            o.opcode = MEM_STORE;                       // Never read undefined words.
        end
        o.zero  = 1'($urandom_range(1));
        o.addr  = (32'(w) << 2) | 32'($urandom_range(3));
        o.wdata = $urandom();
        o.pc    = next_pc;
        next_pc = next_pc + 32'd4;
        exp_res.pc           = o.pc;
        exp_res.rdata        = '0;
        exp_res.branch_taken = 1'b0;
        case (o.opcode)
            MEM_LOAD:   exp_res.rdata = shadow[w];
            MEM_STORE: begin
                shadow[w]  = o.wdata;
                written[w] = 1'b1;
            end
            MEM_BRANCH: exp_res.branch_taken = o.zero;
            default:    ;
        endcase
        expected.push_back(exp_res);
        op_valid <= 1'b1;
        op       <= o;
        credits--;
        issued++;
    endtask

    task automatic start_copy();
        copy_image_t image;
        for (int i = 0; i < COPY_WORDS; i++) begin
            image[i]   = $urandom();
            shadow[i]  = image[i];
            written[i] = 1'b1;
        end
        copy_image <= image;
        copy_start <= 1'b1;
        copies++;
    endtask

    // ----------------------------------------
    // Timeout
    // ----------------------------------------
    always @(posedge clk_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 20 * NUM_OPS + 40 * copies) begin
            abort_run("ERROR: timeout, results stopped arriving");
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        void'($urandom(SEED));
        reset      = 1'b1;
        op_valid   = 1'b0;
        op         = '0;
        copy_start = 1'b0;
        copy_image = '0;
        repeat (8) @(posedge clk_50);
        reset <= 1'b0;
        @(posedge clk_50);
        check("result_valid", 32'(result_valid), 32'd0);
        check("credit_return", 32'(credit_return), 32'd0);
        check("copy_busy", 32'(copy_busy), 32'd0);

        while (issued < NUM_OPS) begin
            tick();
            if (copy_wanted) begin
                // Queue empty, so no earlier op runs after the copy.
                if (credits == QUEUE_DEPTH && copy_busy === 1'b0) begin
                    start_copy();
                    copy_wanted = 1'b0;
                    tick();
                    tick();
                    check("copy_busy", 32'(copy_busy), 32'd1);
                end
            end else if (credits > 0 && $urandom_range(3) != 0) begin
                issue_op();
                if ($urandom_range(99) < 2) begin
                    copy_wanted = 1'b1;
                end
            end
        end

        // Credits come back one cycle ahead of each result.
        while (expected.size() > 0 || copy_busy !== 1'b0) begin
            tick();
        end
        check("credit_return count", 32'(returned), 32'(issued));
        check("credits", 32'(credits), 32'(QUEUE_DEPTH));
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
mem_pkg.sv
mem_request_queue.sv
copy_sequencer.sv
word_counter.sv
data_mem.sv
mem_access.sv
mem_stage.sv
tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mem_stage -f build.f \
    -o tb_mem_stage > build.log 2>&1 \
    && ./obj_dir/tb_mem_stage > sim.log 2>&1
cat sim.log 2>/dev/null || { echo "Build failed, see build.log"; exit 1; }
grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
